// ==== include/irq_hub_defines.svh ====
// widths, vector positions and register addresses of the interrupt hub, included by its sources
`ifndef IRQ_HUB_DEFINES_SVH
`define IRQ_HUB_DEFINES_SVH

// ------------------------------
// widths
// ------------------------------
`define IRQ_NUM_SRC     32
`define IRQ_ID_W        5
`define IRQ_LEVEL_W     8
`define APB_ADDR_W      8
`define APB_DATA_W      32

// ------------------------------
// legacy vector layout
// ------------------------------
`define IRQ_BIT_MSIP    3
`define IRQ_BIT_MTIP    7
`define IRQ_BIT_SEIP    9
`define IRQ_BIT_MEIP    11
`define IRQ_BIT_UART    16
`define IRQ_BIT_TIMER   17   // first of the apb timer lines
`define IRQ_NUM_TIMER   4

`define IRQ_THRESH_ADDR 8'h80 // last valid address, control words sit below

`endif

// ==== source/irq_hub_pkg.sv ====
// shared struct and union types of the interrupt hub, imported by every block that needs them
`include "irq_hub_defines.svh"

package irq_hub_pkg;

  // raw platform interrupt lines
  typedef struct packed {
    logic                      msip;
    logic                      mtip;
    logic                      seip;
    logic                      meip;
    logic                      uart;
    logic [`IRQ_NUM_TIMER-1:0] apb_timer;
  } irq_src_t;

  // ------------------------------
  // apb register port
  // ------------------------------
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // one control word, seen as bus word or as fields
  typedef union packed {
    logic [`APB_DATA_W-1:0] raw;
    struct packed {
      logic [15:0]             rsvd_hi;
      logic [`IRQ_LEVEL_W-1:0] level;   // bits 15:8
      logic [5:0]              rsvd_lo;
      logic                    ip;      // read only, live pending
      logic                    ie;
    } fields;
  } irq_ctl_t;

  // what the arbiter needs per source
  typedef struct packed {
    logic                    ie;
    logic [`IRQ_LEVEL_W-1:0] level;
  } irq_cfg_t;

  // notified source
  typedef struct packed {
    logic [`IRQ_ID_W-1:0]    id;
    logic [`IRQ_LEVEL_W-1:0] level;
  } irq_req_t;

endpackage

// ==== source/irq_src_sync.sv ====
// packs the platform interrupt lines into the legacy vector and synchronizes them to clk_i
`include "irq_hub_defines.svh"

module irq_src_sync (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  irq_hub_pkg::irq_src_t   irq_src_i,   // asynchronous lines
  output logic [`IRQ_NUM_SRC-1:0] pend_vec_o
);

  logic [`IRQ_NUM_SRC-1:0] raw_vec;
  logic [`IRQ_NUM_SRC-1:0] meta_q;   // first stage, may go metastable
  logic [`IRQ_NUM_SRC-1:0] sync_q;

  // ------------------------------
  // vector layout
  // ------------------------------
  always_comb begin
    raw_vec                                    = '0; // reserved bits tied low
    raw_vec[`IRQ_BIT_MSIP]                     = irq_src_i.msip;
    raw_vec[`IRQ_BIT_MTIP]                     = irq_src_i.mtip;
    raw_vec[`IRQ_BIT_SEIP]                     = irq_src_i.seip;
    raw_vec[`IRQ_BIT_MEIP]                     = irq_src_i.meip;
    raw_vec[`IRQ_BIT_UART]                     = irq_src_i.uart;
    raw_vec[`IRQ_BIT_TIMER +: `IRQ_NUM_TIMER]  = irq_src_i.apb_timer; // 20:17
  end

  // ------------------------------
  // two flop synchronizer
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= raw_vec;
      sync_q <= meta_q;
    end
  end

  assign pend_vec_o = sync_q;

endmodule

// ==== source/irq_apb_regs.sv ====
// apb slave holding per-source enable and level plus the global threshold of the interrupt hub
`include "irq_hub_defines.svh"

module irq_apb_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  irq_hub_pkg::apb_req_t                    apb_req_i,
  output irq_hub_pkg::apb_rsp_t                    apb_rsp_o,
  input  logic [`IRQ_NUM_SRC-1:0]                  pend_vec_i,  // for ip readback
  output irq_hub_pkg::irq_cfg_t [`IRQ_NUM_SRC-1:0] cfg_o,
  output logic [`IRQ_LEVEL_W-1:0]                  thresh_o
);

  import irq_hub_pkg::*;

  logic                        access;
  logic                        addr_err;
  logic                        is_thresh;
  logic                        wr_en;
  logic                        rd_en;
  logic [`IRQ_ID_W-1:0]        idx;
  irq_ctl_t                    wr_ctl;
  irq_ctl_t                    rd_ctl;
  irq_cfg_t [`IRQ_NUM_SRC-1:0] cfg_q;
  logic [`IRQ_LEVEL_W-1:0]     thresh_q;

  // ------------------------------
  // address decode
  // ------------------------------
  assign access    = apb_req_i.psel & apb_req_i.penable; // access phase only
  assign addr_err  = (apb_req_i.paddr > `IRQ_THRESH_ADDR) ||
                     (apb_req_i.paddr[1:0] != 2'b00);
  assign is_thresh = (apb_req_i.paddr == `IRQ_THRESH_ADDR);
  assign idx       = apb_req_i.paddr[`IRQ_ID_W+1:2];     // word index
  assign wr_en     = access & apb_req_i.pwrite & ~addr_err;
  assign rd_en     = access & ~apb_req_i.pwrite & ~addr_err;

  assign wr_ctl.raw = apb_req_i.pwdata;

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      thresh_q <= '0;
    end else if (wr_en) begin
      if (is_thresh) begin
        thresh_q <= wr_ctl.raw[`IRQ_LEVEL_W-1:0]; // low byte only
      end else begin
        cfg_q[idx].ie    <= wr_ctl.fields.ie;     // ip is not writable
        cfg_q[idx].level <= wr_ctl.fields.level;
      end
    end
  end

  // ------------------------------
  // read path
  // ------------------------------
  always_comb begin
    rd_ctl.raw = '0;
    if (is_thresh) begin
      rd_ctl.raw[`IRQ_LEVEL_W-1:0] = thresh_q;
    end else begin
      rd_ctl.fields.ie    = cfg_q[idx].ie;
      rd_ctl.fields.level = cfg_q[idx].level;
      rd_ctl.fields.ip    = pend_vec_i[idx];  // live, after sync
    end
  end

  assign apb_rsp_o.prdata  = rd_en ? rd_ctl.raw : '0;
  assign apb_rsp_o.pready  = access;            // no wait states
  assign apb_rsp_o.pslverr = access & addr_err;

  assign cfg_o    = cfg_q;
  assign thresh_o = thresh_q;

endmodule

// ==== source/irq_arbiter.sv ====
// combinational pick of the highest-level enabled pending source above the threshold
`include "irq_hub_defines.svh"

module irq_arbiter (
  input  logic [`IRQ_NUM_SRC-1:0]                  pend_vec_i,
  input  irq_hub_pkg::irq_cfg_t [`IRQ_NUM_SRC-1:0] cfg_i,
  input  logic [`IRQ_LEVEL_W-1:0]                  thresh_i,
  output logic                                     cand_valid_o,
  output irq_hub_pkg::irq_req_t                    cand_o
);

  import irq_hub_pkg::*;

  logic [`IRQ_NUM_SRC-1:0] eligible;
  logic [`IRQ_LEVEL_W-1:0] best_level;
  irq_req_t                best;

  // pending, enabled and strictly above threshold
  always_comb begin
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      eligible[i] = pend_vec_i[i] & cfg_i[i].ie & (cfg_i[i].level > thresh_i);
    end
  end

  // ------------------------------
  // max search
  // ------------------------------
  // scan upward and only replace on a strictly higher level,
  // so on a tie the lower id stays
  always_comb begin
    best_level = thresh_i;   // any eligible level beats this
    best       = '0;
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      if (eligible[i] && (cfg_i[i].level > best_level)) begin
        best_level = cfg_i[i].level;
        best.id    = `IRQ_ID_W'(i);
        best.level = cfg_i[i].level;
      end
    end
  end

  assign cand_valid_o = |eligible;
  assign cand_o       = best;

endmodule

// ==== source/irq_notify.sv ====
// output register that holds the selected interrupt toward the core under valid/ready
module irq_notify (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cand_valid_i,
  input  irq_hub_pkg::irq_req_t cand_i,
  input  logic                  irq_ready_i,
  output logic                  irq_valid_o,
  output irq_hub_pkg::irq_req_t irq_o
);

  import irq_hub_pkg::*;

  logic     valid_q;
  irq_req_t irq_q;
  logic     load;

  // idle or handing over this edge
  // otherwise hold, even if a better candidate shows up
  assign load = ~valid_q | irq_ready_i;

  // ------------------------------
  // notification register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= cand_valid_i;   // goes idle when nothing eligible
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      irq_q <= cand_i;
    end
  end

  assign irq_valid_o = valid_q;
  assign irq_o       = irq_q;

endmodule

// ==== source/irq_hub_top.sv ====
// top of the interrupt hub: source sync, apb registers, arbiter and core notification
`include "irq_hub_defines.svh"

module irq_hub_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  irq_hub_pkg::irq_src_t irq_src_i,
  input  irq_hub_pkg::apb_req_t apb_req_i,
  output irq_hub_pkg::apb_rsp_t apb_rsp_o,
  input  logic                  irq_ready_i,
  output logic                  irq_valid_o,
  output irq_hub_pkg::irq_req_t irq_o
);

  import irq_hub_pkg::*;

  logic [`IRQ_NUM_SRC-1:0]     pend_vec;
  irq_cfg_t [`IRQ_NUM_SRC-1:0] cfg;
  logic [`IRQ_LEVEL_W-1:0]     thresh;
  logic                        cand_valid;
  irq_req_t                    cand;

  // ------------------------------
  // input side
  // ------------------------------
  irq_src_sync i_irq_src_sync (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .irq_src_i  ( irq_src_i ),
    .pend_vec_o ( pend_vec  )
  );

  // ------------------------------
  // processing
  // ------------------------------
  irq_apb_regs i_irq_apb_regs (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .apb_req_i  ( apb_req_i ),
    .apb_rsp_o  ( apb_rsp_o ),
    .pend_vec_i ( pend_vec  ),
    .cfg_o      ( cfg       ),
    .thresh_o   ( thresh    )
  );

  irq_arbiter i_irq_arbiter (
    .pend_vec_i   ( pend_vec   ),
    .cfg_i        ( cfg        ),
    .thresh_i     ( thresh     ),
    .cand_valid_o ( cand_valid ),
    .cand_o       ( cand       )
  );

  // ------------------------------
  // output side
  // ------------------------------
  irq_notify i_irq_notify (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .cand_valid_i ( cand_valid  ),
    .cand_i       ( cand        ),
    .irq_ready_i  ( irq_ready_i ),
    .irq_valid_o  ( irq_valid_o ),
    .irq_o        ( irq_o       )  // to core
  );

endmodule

// ==== dv/irq_hub_properties.sv ====
// concurrent handshake checks for the interrupt hub, bound into irq_hub_top by the testbench
module irq_hub_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input irq_hub_pkg::apb_req_t apb_req_i,
  input irq_hub_pkg::apb_rsp_t apb_rsp_o,
  input logic                  irq_ready_i,
  input logic                  irq_valid_o,
  input irq_hub_pkg::irq_req_t irq_o
);

  // ------------------------------
  // core side
  // ------------------------------
  // back pressure freezes the payload
  property p_irq_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      (irq_valid_o && !irq_ready_i) |=> $stable(irq_o);
  endproperty

  property p_valid_held;  // valid drops only after a transfer
    @(posedge clk_i) disable iff (!rst_ni)
      (irq_valid_o && !irq_ready_i) |=> irq_valid_o;
  endproperty

  // ------------------------------
  // apb side
  // ------------------------------
  property p_no_wait_states;
    @(posedge clk_i) disable iff (!rst_ni)
      (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_o.pready;
  endproperty

  a_irq_stable: assert property (p_irq_stable)
    else $error("irq_o changed while irq_valid_o was high and irq_ready_i low");
  a_valid_held: assert property (p_valid_held)
    else $error("irq_valid_o dropped without a transfer");
  a_no_wait_states: assert property (p_no_wait_states)
    else $error("pready low in an apb access cycle");

endmodule

// ==== dv/irq_hub_tb.sv ====
// table-driven testbench of the interrupt hub, top module of the simulation with the RTL
`include "irq_hub_defines.svh"

module irq_hub_tb;

  import irq_hub_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int WAIT_MAX   = 20;  // cycles allowed for a notification to show up
  localparam int LINE_POS [9] = '{`IRQ_BIT_MSIP, `IRQ_BIT_MTIP, `IRQ_BIT_SEIP, `IRQ_BIT_MEIP,
                                  `IRQ_BIT_UART, `IRQ_BIT_TIMER, `IRQ_BIT_TIMER + 1,
                                  `IRQ_BIT_TIMER + 2, `IRQ_BIT_TIMER + 3};

  typedef enum logic [1:0] {K_WR, K_RD, K_SRC, K_ACC} kind_e;

  typedef struct packed {
    kind_e                  kind;
    logic [`APB_ADDR_W-1:0] addr;
    logic [`APB_DATA_W-1:0] data;       // write data or expected read data
    logic                   exp_err;
    irq_src_t               src;
    logic                   exp_valid;  // low means the output must stay idle
    irq_req_t               exp_irq;
  } entry_t;

  logic     clk_i;
  logic     rst_ni;
  irq_src_t irq_src_i;
  apb_req_t apb_req_i;
  apb_rsp_t apb_rsp_o;
  logic     irq_ready_i;
  logic     irq_valid_o;
  irq_req_t irq_o;

  // reference model, advanced while the table is built
  logic [`IRQ_NUM_SRC-1:0] m_ie;
  logic [`IRQ_LEVEL_W-1:0] m_level [`IRQ_NUM_SRC];
  logic [`IRQ_LEVEL_W-1:0] m_thresh;
  irq_src_t                m_src;
  logic                    m_valid;  // model of the notification register
  irq_req_t                m_held;

  entry_t      table_q [$];
  int unsigned n_entries;
  logic [31:0] lcg_state;

  irq_hub_top uut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .irq_src_i   ( irq_src_i   ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_o   ( apb_rsp_o   ),
    .irq_ready_i ( irq_ready_i ),
    .irq_valid_o ( irq_valid_o ),
    .irq_o       ( irq_o       )
  );

  bind irq_hub_top irq_hub_properties i_irq_hub_properties (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_o   ( apb_rsp_o   ),
    .irq_ready_i ( irq_ready_i ),
    .irq_valid_o ( irq_valid_o ),
    .irq_o       ( irq_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [`IRQ_NUM_SRC-1:0] line_vector(input irq_src_t s);
    logic [`IRQ_NUM_SRC-1:0] v;
    v                                     = '0;
    v[`IRQ_BIT_MSIP]                      = s.msip;
    v[`IRQ_BIT_MTIP]                      = s.mtip;
    v[`IRQ_BIT_SEIP]                      = s.seip;
    v[`IRQ_BIT_MEIP]                      = s.meip;
    v[`IRQ_BIT_UART]                      = s.uart;
    v[`IRQ_BIT_TIMER +: `IRQ_NUM_TIMER]   = s.apb_timer;
    return v;
  endfunction

  // notification register loads the best eligible source, lowest id on a tie
  function automatic void model_load();
    logic [`IRQ_NUM_SRC-1:0] pend;
    pend    = line_vector(m_src);
    m_valid = 1'b0;
    m_held  = '0;
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      if (pend[i] && m_ie[i] && (m_level[i] > m_thresh) &&
          (!m_valid || (m_level[i] > m_held.level))) begin
        m_valid      = 1'b1;
        m_held.id    = `IRQ_ID_W'(i);
        m_held.level = m_level[i];
      end
    end
  endfunction

  function automatic logic [31:0] ctl_word(input logic ie, input logic [7:0] level);
    return {16'h0, level, 6'h0, 1'b0, ie};
  endfunction

  // ------------------------------
  // table rows
  // ------------------------------
  function automatic void add_apb(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                                  input logic [`APB_DATA_W-1:0] wdata);
    entry_t                  e;
    logic [`IRQ_NUM_SRC-1:0] pend;
    logic [`IRQ_ID_W-1:0]    idx;
    e         = '0;
    e.kind    = wr ? K_WR : K_RD;
    e.addr    = addr;
    e.exp_err = (addr > `IRQ_THRESH_ADDR) || (addr[1:0] != 2'b00);
    idx       = addr[`IRQ_ID_W+1:2];
    pend      = line_vector(m_src);
    if (wr) begin
      e.data = wdata;
      if (!e.exp_err && (addr == `IRQ_THRESH_ADDR)) begin
        m_thresh = wdata[`IRQ_LEVEL_W-1:0];
      end else if (!e.exp_err) begin
        m_ie[idx]    = wdata[0];
        m_level[idx] = wdata[15:8];
      end
    end else if (!e.exp_err) begin
      e.data = (addr == `IRQ_THRESH_ADDR) ? {24'h0, m_thresh} :
               {16'h0, m_level[idx], 6'h0, pend[idx], m_ie[idx]};
    end  // error reads stay zero
    table_q.push_back(e);
    if (!m_valid) model_load();
  endfunction

  function automatic void add_src(input irq_src_t s);
    entry_t e;
    e      = '0;
    e.kind = K_SRC;
    e.src  = s;
    m_src  = s;
    table_q.push_back(e);
    if (!m_valid) model_load();
  endfunction

  function automatic void add_accept();
    entry_t e;
    e           = '0;
    e.kind      = K_ACC;
    e.exp_valid = m_valid;
    e.exp_irq   = m_held;
    table_q.push_back(e);
    if (m_valid) model_load();  // transfer edge reloads
  endfunction

  task automatic build_table();
    irq_src_t    s;
    logic [31:0] r;
    int          k;
    lcg_state = 32'd57868;
    m_ie      = '0;
    m_thresh  = '0;
    m_src     = '0;
    m_valid   = 1'b0;
    m_held    = '0;
    foreach (m_level[i]) m_level[i] = '0;
    // reset values, sources without enables stay silent
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      add_apb(1'b0, `APB_ADDR_W'(i * 4), '0);
    end
    add_apb(1'b0, `IRQ_THRESH_ADDR, '0);
    s = '0;
    s.msip = 1'b1;
    s.uart = 1'b1;
    add_src(s);
    add_accept();
    add_src('0);
    add_accept();
    // write with reserved and ip bits set, read back
    add_apb(1'b1, 8'h0C, 32'hA5A5_C3FF);
    s = '0;
    s.msip = 1'b1;
    add_src(s);
    add_apb(1'b0, 8'h0C, '0);
    add_accept();
    add_src('0);
    add_accept();
    // slave errors
    add_apb(1'b1, 8'h84, ctl_word(1'b1, 8'hFF));
    add_apb(1'b1, 8'h06, ctl_word(1'b1, 8'hFF));
    add_apb(1'b0, 8'h84, '0);
    add_apb(1'b0, 8'h05, '0);
    add_apb(1'b0, 8'h04, '0);
    // highest level wins, msip before mtip on a tie
    add_apb(1'b1, 8'h0C, ctl_word(1'b1, 8'h40));
    add_apb(1'b1, 8'h1C, ctl_word(1'b1, 8'h40));
    add_apb(1'b1, 8'h24, ctl_word(1'b1, 8'h20));
    add_apb(1'b1, 8'h2C, ctl_word(1'b1, 8'h70));
    s = '0;
    s.msip = 1'b1;
    s.mtip = 1'b1;
    s.seip = 1'b1;
    add_src(s);
    add_accept();
    add_src('0);
    add_accept();
    s.msip = 1'b0;
    s.meip = 1'b1;
    add_src(s);
    add_accept();
    add_src('0);
    add_accept();
    // threshold, only the low byte is kept
    add_apb(1'b1, `IRQ_THRESH_ADDR, 32'hFFFF_FF50);
    add_apb(1'b0, `IRQ_THRESH_ADDR, '0);
    add_apb(1'b1, 8'h40, ctl_word(1'b1, 8'h50));
    s = '0;
    s.uart = 1'b1;
    add_src(s);
    add_accept();
    add_apb(1'b1, `IRQ_THRESH_ADDR, 32'h0000_004F);
    add_accept();
    add_src('0);
    add_accept();
    // back pressure while a better source rises
    add_apb(1'b1, `IRQ_THRESH_ADDR, '0);
    add_apb(1'b1, 8'h44, ctl_word(1'b1, 8'h10));
    add_apb(1'b1, 8'h50, ctl_word(1'b1, 8'h90));
    s = '0;
    s.apb_timer = 4'b0001;
    add_src(s);
    s.apb_timer = 4'b1001;
    add_src(s);
    add_accept();
    add_accept();
    add_src('0);
    add_accept();
    // random rounds
    for (int n = 0; n < 10; n++) begin
      r = lcg_next();
      k = int'(r[31:28]) % 9;
      add_apb(1'b1, `APB_ADDR_W'(LINE_POS[k] * 4), ctl_word(r[27] | r[26], r[23:16]));
      add_apb(1'b1, `IRQ_THRESH_ADDR, {26'h0, r[21:16]});
      r = lcg_next();
      add_src(irq_src_t'(r[24:16]));
      add_apb(1'b0, `APB_ADDR_W'(LINE_POS[k] * 4), '0);
      add_accept();
    end
  endtask

  // ------------------------------
  // checks and drivers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic apb_xfer(input entry_t e);
    @(negedge clk_i);
    apb_req_i.psel    = 1'b1;  // setup
    apb_req_i.penable = 1'b0;
    apb_req_i.pwrite  = (e.kind == K_WR);
    apb_req_i.paddr   = e.addr;
    apb_req_i.pwdata  = (e.kind == K_WR) ? e.data : '0;
    @(negedge clk_i);
    apb_req_i.penable = 1'b1;
    #(CLK_PERIOD / 4);         // sample mid access cycle
    check_value("apb_rsp_o.pready", 32'(apb_rsp_o.pready), 32'd1);
    check_value("apb_rsp_o.pslverr", 32'(apb_rsp_o.pslverr), 32'(e.exp_err));
    if (e.kind == K_RD) check_value("apb_rsp_o.prdata", apb_rsp_o.prdata, e.data);
    @(negedge clk_i);
    apb_req_i = '0;
    @(negedge clk_i);          // config change reaches the output register
  endtask

  task automatic drive_sources(input irq_src_t s);
    @(negedge clk_i);
    irq_src_i = s;
    repeat (3) @(posedge clk_i);
  endtask

  task automatic accept_irq(input entry_t e);
    int waited;
    waited = 0;
    @(negedge clk_i);
    if (!e.exp_valid) begin
      check_value("irq_valid_o", 32'(irq_valid_o), 32'd0);
    end else begin
      while (!irq_valid_o && (waited < WAIT_MAX)) begin
        @(negedge clk_i);
        waited++;
      end
      if (!irq_valid_o) begin
        $display("no notification from the DUT within %0d cycles at %0t", WAIT_MAX, $time);
        $display("Finished with errors");
        $fatal(1, "notification missing");
      end else begin
        check_value("irq_o.id", 32'(irq_o.id), 32'(e.exp_irq.id));
        check_value("irq_o.level", 32'(irq_o.level), 32'(e.exp_irq.level));
        irq_ready_i = 1'b1;
        @(negedge clk_i);
        irq_ready_i = 1'b0;
      end
    end
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    irq_src_i   = '0;
    apb_req_i   = '0;
    irq_ready_i = 1'b0;
    rst_ni      = 1'b0;
    build_table();
    n_entries = table_q.size();
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      case (table_q[i].kind)
        K_WR, K_RD: apb_xfer(table_q[i]);
        K_SRC:      drive_sources(table_q[i].src);
        default:    accept_irq(table_q[i]);
      endcase
    end
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    wait (n_entries != 0);
    repeat (n_entries * 50 + 8) @(posedge clk_i);
    $display("timeout: table of %0d entries did not complete in time", n_entries);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== sources.f ====
+incdir+include
source/irq_hub_pkg.sv
source/irq_src_sync.sv
source/irq_apb_regs.sv
source/irq_arbiter.sv
source/irq_notify.sv
source/irq_hub_top.sv
dv/irq_hub_properties.sv
dv/irq_hub_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the interrupt hub testbench with Verilator and run it
# the exit status is the simulator's, nonzero when the run fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module irq_hub_tb \
  -o irq_hub_sim

./obj_dir/irq_hub_sim
